// ==== source/pipe_defs.svh ====
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

//////////////////////////////////////////////////
// Core sizing
//////////////////////////////////////////////////

// Data path width in bits
`define WORD_SIZE 32

// Architectural integer registers
`define NUM_REGS 32

// Instruction memory depth in words
`define NUM_WORDS 1024

// Derived index widths
`define REG_SEL $clog2(`NUM_REGS)
`define ADDR_SIZE $clog2(`NUM_WORDS)

`endif

// ==== source/alu_pkg.sv ====
package alu_pkg;

    //////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////

    // RV32I integer operations, shared by R and I forms
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        // Compares return 1 or 0
        SLT  = 4'd8,
        SLTU = 4'd9
    } alu_op_t;

    //////////////////////////////////////////////////
    // Operand forwarding select
    //////////////////////////////////////////////////

    // Source of an ALU operand
    typedef enum logic [1:0] {
        // Value read from the register file in decode
        FWD_REG = 2'd0,
        // Result sitting in EX/MEM
        FWD_MEM = 2'd1,
        // Data on the write-back bus
        FWD_WB  = 2'd2
    } fwd_sel_t;

endpackage

// ==== source/pipe_pkg.sv ====
`include "pipe_defs.svh"

package pipe_pkg;

    import alu_pkg::*;

    //////////////////////////////////////////////////
    // ID/EX payload
    //////////////////////////////////////////////////

    // Decoded instruction entering execute
    typedef struct packed {
        logic                    valid;
        // PC of the next instruction, word address
        logic [`ADDR_SIZE-1:0]   pc;
        logic [`REG_SEL-1:0]     rs1;
        logic [`REG_SEL-1:0]     rs2;
        logic [`REG_SEL-1:0]     rd;
        // Register file read data
        logic [`WORD_SIZE-1:0]   data1;
        logic [`WORD_SIZE-1:0]   data2;
        logic [`WORD_SIZE-1:0]   immd;
        alu_op_t                 alu_op;
        // Use immd as ALU operand B
        logic                    alu_src;
        logic                    branch;
        logic                    jump;
        logic                    reg_write;
        logic                    mem_read;
        logic                    mem_write;
    } id_ex_t;

    //////////////////////////////////////////////////
    // EX/MEM payload
    //////////////////////////////////////////////////

    // Execute result handed to the memory stage
    typedef struct packed {
        logic                    valid;
        logic [`REG_SEL-1:0]     rd;
        // ALU output, also the memory address
        logic [`WORD_SIZE-1:0]   result;
        // Store data
        logic [`WORD_SIZE-1:0]   write_data;
        logic [`ADDR_SIZE-1:0]   branch_target;
        // Flag for the branch decision in MEM
        logic                    zero;
        logic                    branch;
        logic                    jump;
        logic                    reg_write;
        logic                    mem_read;
        logic                    mem_write;
    } ex_mem_t;

    // Write-back bus from the last stage
    typedef struct packed {
        logic                    reg_write;
        logic [`REG_SEL-1:0]     rd;
        logic [`WORD_SIZE-1:0]   data;
    } wb_bus_t;

endpackage

// ==== source/alu.sv ====
`timescale 1ns/100ps

`include "pipe_defs.svh"

module alu
    import alu_pkg::*;
(
    input  alu_op_t                 alu_op,
    input  logic [`WORD_SIZE-1:0]   a,
    input  logic [`WORD_SIZE-1:0]   b,
    output logic [`WORD_SIZE-1:0]   result,
    output logic                    zero
);

    // Shift amount from the low bits of B
    logic [4:0] shamt;

    // Compare outcomes
    logic lt_signed;
    logic lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    always_comb begin
        unique case (alu_op)
            ADD:  result = a + b;
            SUB:  result = a - b;
            AND:  result = a & b;
            OR:   result = a | b;
            XOR:  result = a ^ b;
            SLL:  result = a << shamt;
            SRL:  result = a >> shamt;
            // Arithmetic shift keeps the sign bit
            SRA:  result = $signed(a) >>> shamt;
            SLT: begin
                result    = '0;
                result[0] = lt_signed;
            end
            SLTU: begin
                result    = '0;
                result[0] = lt_unsigned;
            end
            // Unused encodings give zero
            default: result = '0;
        endcase
    end

    // All-zero result
    assign zero = (result == '0);

endmodule

// ==== source/forward_unit.sv ====
`timescale 1ns/100ps

`include "pipe_defs.svh"

module forward_unit
    import alu_pkg::*;
    import pipe_pkg::*;
(
    input  logic [`REG_SEL-1:0] rs1,
    input  logic [`REG_SEL-1:0] rs2,
    input  ex_mem_t             ex_mem,
    input  wb_bus_t             wb,
    output fwd_sel_t            sel_forward1,
    output fwd_sel_t            sel_forward2
);

    // Producer qualifiers
    logic mem_writes;
    logic wb_writes;

    // EX/MEM only counts when it holds a real instruction
    assign mem_writes = ex_mem.valid && ex_mem.reg_write && (ex_mem.rd != '0);

    // x0 is never a forwarding source
    assign wb_writes = wb.reg_write && (wb.rd != '0);

    //////////////////////////////////////////////////
    // Operand 1
    //////////////////////////////////////////////////

    // Newer result in MEM wins over WB
    always_comb begin
        if (mem_writes && (ex_mem.rd == rs1)) begin
            sel_forward1 = FWD_MEM;
        end else if (wb_writes && (wb.rd == rs1)) begin
            sel_forward1 = FWD_WB;
        end else begin
            sel_forward1 = FWD_REG;
        end
    end

    //////////////////////////////////////////////////
    // Operand 2
    //////////////////////////////////////////////////

    always_comb begin
        if (mem_writes && (ex_mem.rd == rs2)) begin
            sel_forward2 = FWD_MEM;
        end else if (wb_writes && (wb.rd == rs2)) begin
            sel_forward2 = FWD_WB;
        end else begin
            sel_forward2 = FWD_REG;
        end
    end

endmodule

// ==== source/ex_stage.sv ====
`timescale 1ns/100ps

`include "pipe_defs.svh"

module ex_stage
    import alu_pkg::*;
    import pipe_pkg::*;
(
    input  id_ex_t                  id_ex,
    input  logic [`WORD_SIZE-1:0]   mem_forward,
    input  logic [`WORD_SIZE-1:0]   wb_forward,
    input  fwd_sel_t                sel_forward1,
    input  fwd_sel_t                sel_forward2,
    output ex_mem_t                 ex_mem
);

    // Forwarded operands and ALU inputs
    logic [`WORD_SIZE-1:0] operand1;
    logic [`WORD_SIZE-1:0] operand2;
    logic [`WORD_SIZE-1:0] alu_b;
    logic [`WORD_SIZE-1:0] alu_result;
    logic                  alu_zero;

    // Immediate scaled to bytes
    logic [`WORD_SIZE-1:0] immd_scaled;

    //////////////////////////////////////////////////
    // Operand muxes
    //////////////////////////////////////////////////

    always_comb begin
        case (sel_forward1)
            FWD_MEM: operand1 = mem_forward;
            FWD_WB:  operand1 = wb_forward;
            default: operand1 = id_ex.data1;
        endcase
    end

    always_comb begin
        case (sel_forward2)
            FWD_MEM: operand2 = mem_forward;
            FWD_WB:  operand2 = wb_forward;
            default: operand2 = id_ex.data2;
        endcase
    end

    // Immediate replaces operand 2 on the B side
    assign alu_b = id_ex.alu_src ? id_ex.immd : operand2;

    alu u_alu (
        .alu_op (id_ex.alu_op),
        .a      (operand1),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign immd_scaled = id_ex.immd << 2;

    //////////////////////////////////////////////////
    // Result packing
    //////////////////////////////////////////////////

    always_comb begin
        ex_mem            = '0;
        ex_mem.valid      = id_ex.valid;
        ex_mem.rd         = id_ex.rd;
        ex_mem.result     = alu_result;
        // Store data is the forwarded rs2
        ex_mem.write_data = operand2;
        // Target truncated to the PC width
        ex_mem.branch_target = (id_ex.branch || id_ex.jump)
                             ? id_ex.pc + immd_scaled[`ADDR_SIZE-1:0]
                             : id_ex.pc;
        // Compares report through bit 0
        ex_mem.zero = (id_ex.alu_op == SLT || id_ex.alu_op == SLTU)
                    ? alu_result[0] : alu_zero;
        ex_mem.branch    = id_ex.branch;
        ex_mem.jump      = id_ex.jump;
        ex_mem.reg_write = id_ex.reg_write;
        ex_mem.mem_read  = id_ex.mem_read;
        ex_mem.mem_write = id_ex.mem_write;
    end

endmodule

// ==== source/pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
    // Stage payload
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    // Hold the current contents
    input  logic     stall,
    // Replace the contents with a bubble
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////

    // Flush ranks above stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            // All-zero payload is a bubble
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// ==== source/ex_pipeline.sv ====
`timescale 1ns/100ps

module ex_pipeline
    import alu_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    // Pipeline control levels
    input  logic    stall,
    input  logic    flush,
    // Decoded instruction from ID
    input  id_ex_t  id_ex_in,
    // Write-back bus
    input  wb_bus_t wb_in,
    // Execute result toward MEM
    output ex_mem_t ex_mem_out
);

    // Registered decode payload
    id_ex_t   id_ex_q;

    // Unregistered execute result
    ex_mem_t  ex_mem_d;

    // Operand source selects
    fwd_sel_t sel_forward1;
    fwd_sel_t sel_forward2;

    //////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////

    // Held while stalled, bubbled on flush
    pipe_reg #(
        .payload_t (id_ex_t)
    ) id_ex_reg (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .d     (id_ex_in),
        .q     (id_ex_q)
    );

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////

    forward_unit u_forward_unit (
        .rs1          (id_ex_q.rs1),
        .rs2          (id_ex_q.rs2),
        .ex_mem       (ex_mem_out),
        .wb           (wb_in),
        .sel_forward1 (sel_forward1),
        .sel_forward2 (sel_forward2)
    );

    ex_stage u_ex_stage (
        .id_ex        (id_ex_q),
        .mem_forward  (ex_mem_out.result),
        .wb_forward   (wb_in.data),
        .sel_forward1 (sel_forward1),
        .sel_forward2 (sel_forward2),
        .ex_mem       (ex_mem_d)
    );

    //////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////

    // Stall cycles insert a bubble here instead of holding
    pipe_reg #(
        .payload_t (ex_mem_t)
    ) ex_mem_reg (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .flush (stall),
        .d     (ex_mem_d),
        .q     (ex_mem_out)
    );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
    // Half of the 100 ns period
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on a falling edge clear of the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== dv/ex_pipeline_tb.sv ====
`timescale 1ns/100ps

`include "pipe_defs.svh"

module ex_pipeline_tb
    import alu_pkg::*;
    import pipe_pkg::*;
();

    localparam int NUM_RANDOM = 200;

    // Inputs applied on one falling edge
    typedef struct packed {
        logic    stall;
        logic    flush;
        id_ex_t  instr;
        wb_bus_t wb;
    } step_t;

    logic    clk;
    logic    reset;
    logic    stall;
    logic    flush;
    id_ex_t  id_ex_in;
    wb_bus_t wb_in;
    ex_mem_t ex_mem_out;

    step_t       stim_q[$];
    int          total_steps;
    logic [31:0] lcg_state;

    // Model of ID/EX contents
    id_ex_t  held;
    // Model of the last committed EX/MEM entry
    ex_mem_t exp_out;
    logic    checking = 1'b0;

    tb_clock clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    ex_pipeline uut (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .id_ex_in   (id_ex_in),
        .wb_in      (wb_in),
        .ex_mem_out (ex_mem_out)
    );

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic stop_failed();
        $display("TEST FAILED");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
        stop_failed();
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [4:0] control_bits(ex_mem_t e);
        return {e.branch, e.jump, e.reg_write, e.mem_read, e.mem_write};
    endfunction

    function automatic logic [`WORD_SIZE-1:0] expected_alu_result(alu_op_t op,
            logic [31:0] a, logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh = b[4:0];
        // Sign bits shifted in from the top
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (op)
            ADD:  return a + b;
            SUB:  return a + ~b + 32'd1;
            AND:  return a & b;
            OR:   return a | b;
            XOR:  return a ^ b;
            SLL:  return a << sh;
            SRL:  return a >> sh;
            SRA:  return (a >> sh) | fill;
            // Differing signs decide a signed compare
            SLT:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            SLTU: return {31'b0, a < b};
            default: return '0;
        endcase
    endfunction

    // MEM ahead of WB, never x0, never a bubble
    function automatic logic [31:0] expected_operand(logic [`REG_SEL-1:0] rs,
            logic [31:0] reg_data, wb_bus_t wb);
        if (exp_out.valid && exp_out.reg_write && rs != 0 && exp_out.rd == rs) begin
            return exp_out.result;
        end
        if (wb.reg_write && rs != 0 && wb.rd == rs) begin
            return wb.data;
        end
        return reg_data;
    endfunction

    function automatic ex_mem_t predict_ex_mem(id_ex_t ins, wb_bus_t wb);
        ex_mem_t               e;
        logic [31:0]           op1;
        logic [31:0]           op2;
        logic [`ADDR_SIZE-1:0] target;
        e   = '0;
        op1 = expected_operand(ins.rs1, ins.data1, wb);
        op2 = expected_operand(ins.rs2, ins.data2, wb);
        // Byte offset of a word immediate wrapping at the PC width
        target = ins.pc + ins.immd * 4;
        e.valid      = ins.valid;
        e.rd         = ins.rd;
        e.result     = expected_alu_result(ins.alu_op, op1, ins.alu_src ? ins.immd : op2);
        e.write_data = op2;
        e.branch_target = (ins.branch || ins.jump) ? target : ins.pc;
        if (ins.alu_op == SLT || ins.alu_op == SLTU) begin
            e.zero = e.result[0];
        end else begin
            e.zero = (e.result == 0);
        end
        e.branch    = ins.branch;
        e.jump      = ins.jump;
        e.reg_write = ins.reg_write;
        e.mem_read  = ins.mem_read;
        e.mem_write = ins.mem_write;
        return e;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Small register range to provoke hazards
    function automatic id_ex_t random_instr(alu_op_t op, logic src);
        id_ex_t      ins;
        logic [31:0] r;
        r   = next_rand();
        ins = '0;
        ins.valid     = 1'b1;
        ins.pc        = r[`ADDR_SIZE-1:0];
        ins.rs1       = {2'b00, r[12:10]};
        ins.rs2       = {2'b00, r[15:13]};
        ins.rd        = {2'b00, r[18:16]};
        ins.branch    = r[19] & r[20];
        ins.jump      = r[21] & r[22];
        ins.reg_write = r[23] | r[24];
        ins.mem_read  = r[25] & r[26];
        ins.mem_write = r[27] & r[28];
        ins.data1     = next_rand();
        ins.data2     = next_rand();
        ins.immd      = next_rand();
        ins.alu_op    = op;
        ins.alu_src   = src;
        return ins;
    endfunction

    function automatic wb_bus_t random_wb();
        wb_bus_t     wb;
        logic [31:0] r;
        r = next_rand();
        wb.reg_write = r[0];
        wb.rd        = {2'b00, r[3:1]};
        wb.data      = next_rand();
        return wb;
    endfunction

    task automatic add_step(logic stall_lvl, logic flush_lvl, id_ex_t instr, wb_bus_t wb);
        step_t s;
        s.stall = stall_lvl;
        s.flush = flush_lvl;
        s.instr = instr;
        s.wb    = wb;
        stim_q.push_back(s);
    endtask

    // Producer, consumer, then wb_in seen while the consumer executes
    task automatic add_pair(id_ex_t first, id_ex_t second, wb_bus_t wb_next);
        add_step(1'b0, 1'b0, first, '0);
        add_step(1'b0, 1'b0, second, '0);
        add_step(1'b0, 1'b0, random_instr(ADD, 1'b1), wb_next);
    endtask

    task automatic build_stimulus();
        id_ex_t      a;
        id_ex_t      b;
        wb_bus_t     wb;
        logic [31:0] r;
        // Idle after reset before any issue
        repeat (3) add_step(1'b0, 1'b0, '0, '0);
        // Every operation in register and immediate form
        for (int op = 0; op < 10; op++) begin
            add_step(1'b0, 1'b0, random_instr(alu_op_t'(op), 1'b0), random_wb());
            add_step(1'b0, 1'b0, random_instr(alu_op_t'(op), 1'b1), random_wb());
        end
        // Equal operands give a zero result
        a = random_instr(SUB, 1'b0);
        a.rs1   = '0;
        a.rs2   = '0;
        a.data2 = a.data1;
        add_step(1'b0, 1'b0, a, '0);
        // Dependent pair with a matching WB, EX/MEM must win
        a = random_instr(ADD, 1'b0);
        a.rd        = 5'd5;
        a.reg_write = 1'b1;
        b = random_instr(XOR, 1'b0);
        b.rs1 = 5'd5;
        b.rs2 = 5'd5;
        wb.reg_write = 1'b1;
        wb.rd        = 5'd5;
        wb.data      = 32'hdead_beef;
        add_pair(a, b, wb);
        // x0 as producer and on the WB bus
        a.rd  = '0;
        b.rs1 = '0;
        b.rs2 = '0;
        wb.rd = '0;
        add_pair(a, b, wb);
        // Invalid producer, operand falls through to WB
        a.valid = 1'b0;
        a.rd    = 5'd7;
        b.rs1   = 5'd7;
        wb.rd   = 5'd7;
        add_pair(a, b, wb);
        // Stall holds the issued instruction and drops the one offered meanwhile
        add_step(1'b0, 1'b0, random_instr(ADD, 1'b0), '0);
        add_step(1'b1, 1'b0, random_instr(SUB, 1'b0), random_wb());
        add_step(1'b0, 1'b0, random_instr(AND, 1'b1), random_wb());
        // Flush alone turns the offered instruction into a bubble
        add_step(1'b0, 1'b1, random_instr(OR, 1'b0), '0);
        // Flush beats stall on a live ID/EX entry
        add_step(1'b0, 1'b0, random_instr(XOR, 1'b0), random_wb());
        add_step(1'b1, 1'b1, random_instr(SLT, 1'b0), random_wb());
        add_step(1'b0, 1'b0, random_instr(SLTU, 1'b1), random_wb());
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = next_rand();
            add_step(r[2:0] == 3'd0, r[6:3] == 4'd0,
                     random_instr(alu_op_t'(r[10:7] % 4'd10), r[11]), random_wb());
        end
        // Drain
        repeat (3) add_step(1'b0, 1'b0, '0, '0);
    endtask

    //////////////////////////////////////////////////
    // Checks on each falling edge
    //////////////////////////////////////////////////

    check_valid: assert property (@(negedge clk)
        !checking || ex_mem_out.valid == exp_out.valid)
        else report_mismatch("ex_mem_out.valid", $sampled(exp_out.valid),
                             $sampled(ex_mem_out.valid));

    // branch, jump, reg_write, mem_read, mem_write
    check_controls: assert property (@(negedge clk)
        !checking || control_bits(ex_mem_out) == control_bits(exp_out))
        else report_mismatch("ex_mem_out controls", control_bits($sampled(exp_out)),
                             control_bits($sampled(ex_mem_out)));

    check_rd: assert property (@(negedge clk)
        !checking || !exp_out.valid || ex_mem_out.rd == exp_out.rd)
        else report_mismatch("ex_mem_out.rd", $sampled(exp_out.rd),
                             $sampled(ex_mem_out.rd));

    check_result: assert property (@(negedge clk)
        !checking || !exp_out.valid || ex_mem_out.result == exp_out.result)
        else report_mismatch("ex_mem_out.result", $sampled(exp_out.result),
                             $sampled(ex_mem_out.result));

    check_write_data: assert property (@(negedge clk)
        !checking || !exp_out.valid || ex_mem_out.write_data == exp_out.write_data)
        else report_mismatch("ex_mem_out.write_data", $sampled(exp_out.write_data),
                             $sampled(ex_mem_out.write_data));

    check_target: assert property (@(negedge clk)
        !checking || !exp_out.valid || ex_mem_out.branch_target == exp_out.branch_target)
        else report_mismatch("ex_mem_out.branch_target", $sampled(exp_out.branch_target),
                             $sampled(ex_mem_out.branch_target));

    check_zero: assert property (@(negedge clk)
        !checking || !exp_out.valid || ex_mem_out.zero == exp_out.zero)
        else report_mismatch("ex_mem_out.zero", $sampled(exp_out.zero),
                             $sampled(ex_mem_out.zero));

    //////////////////////////////////////////////////
    // Drive and predict
    //////////////////////////////////////////////////

    initial begin
        step_t   s;
        ex_mem_t next_out;
        stall       = 1'b0;
        flush       = 1'b0;
        // Live instruction offered while reset must keep both registers empty
        id_ex_in           = '0;
        id_ex_in.valid     = 1'b1;
        id_ex_in.jump      = 1'b1;
        id_ex_in.reg_write = 1'b1;
        id_ex_in.mem_write = 1'b1;
        wb_in       = '0;
        held        = '0;
        exp_out     = '0;
        lcg_state   = 32'h630d592f;
        total_steps = 0;
        build_stimulus();
        total_steps = stim_q.size();
        // Bubbles expected on every falling edge of reset
        checking    = 1'b1;
        @(negedge reset);
        while (stim_q.size() > 0) begin
            s = stim_q.pop_front();
            stall    = s.stall;
            flush    = s.flush;
            id_ex_in = s.instr;
            wb_in    = s.wb;
            // EX/MEM after the coming edge or a bubble while stalled
            next_out = s.stall ? ex_mem_t'('0) : predict_ex_mem(held, s.wb);
            // ID/EX after the coming edge
            if (s.flush) begin
                held = '0;
            end else if (!s.stall) begin
                held = s.instr;
            end
            exp_out  = next_out;
            checking = 1'b1;
            @(negedge clk);
        end
        checking = 1'b0;
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

    // One cycle per step plus slack for reset and drain
    initial begin
        wait (total_steps > 0);
        #((total_steps + 50) * 100);
        $display("Run timed out before all stimulus was applied");
        stop_failed();
    end

endmodule

// ==== tb.f ====
+incdir+source
source/alu_pkg.sv
source/pipe_pkg.sv
source/alu.sv
source/forward_unit.sv
source/ex_stage.sv
source/pipe_reg.sv
source/ex_pipeline.sv
dv/tb_clock.sv
dv/ex_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: ex_pipeline

sources:
  - include_dirs:
      - source
    files:
      - source/alu_pkg.sv
      - source/pipe_pkg.sv
      - source/alu.sv
      - source/forward_unit.sv
      - source/ex_stage.sv
      - source/pipe_reg.sv
      - source/ex_pipeline.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_clock.sv
      - dv/ex_pipeline_tb.sv
